// ==== include/dsi_defs.svh ====
// dsi core shared constants for lane count, widths, register map and clock pattern
`ifndef DSI_DEFS_SVH
`define DSI_DEFS_SVH

// lane count and datapath widths
`define DSI_NUM_LANES 3
`define DSI_ADDR_W 6
`define DSI_DATA_W 32
`define DSI_TICK_W 12

// register map
`define DSI_REG_TICK_DIV 6'h00
`define DSI_REG_CTL 6'h01
`define DSI_REG_LP_TX 6'h02
`define DSI_REG_GPIO 6'h03
`define DSI_REG_LANE_CTRL 6'h04

// high-speed byte on the clock lane
`define DSI_CLK_PATTERN 8'haa

`endif

// ==== verilog/dsi_reg_pkg.sv ====
// dsi register types, the decoded views of one register word
`default_nettype none
`include "dsi_defs.svh"

package dsi_reg_pkg;

   typedef logic [1:0] lane_route_t;

   // CTL, esc_ready is a read-only status bit
   typedef struct packed {
      logic [`DSI_DATA_W-4:0] rsvd;
      logic esc_ready;
      logic lp_request;
      logic clk_en;
   } ctl_word_s;

   typedef struct packed {
      logic [`DSI_DATA_W-10:0] rsvd;
      logic valid;
      logic [7:0] data;
   } lp_tx_word_s;

   // route[0] sits in bits 1:0
   typedef struct packed {
      logic [`DSI_DATA_W-14:0] rsvd;
      logic clock_invert;
      logic [3:0] invert;
      lane_route_t [3:0] route;
   } lane_word_s;

   typedef struct packed {
      logic [`DSI_DATA_W-5:0] rsvd;
      logic [2:0] gpio;
      logic reset_n;
   } gpio_word_s;

   typedef union packed {
      ctl_word_s ctl;
      lp_tx_word_s lp_tx;
      lane_word_s lane;
      gpio_word_s gpio;
      logic [`DSI_DATA_W-1:0] raw;
   } csr_word_u;

endpackage

`default_nettype wire

// ==== verilog/dsi_lane_pkg.sv ====
// dsi lane types for line states and the lane sequencers
`default_nettype none

package dsi_lane_pkg;

   // {p, n} as driven on the wire
   typedef enum logic [1:0] {
      LP00 = 2'b00,
      LP01 = 2'b01,
      LP10 = 2'b10,
      LP11 = 2'b11
   } lp_state_e;

   // escape serializer
   typedef enum logic [1:0] {
      ESC_IDLE,
      ESC_BIT,
      ESC_SPACE
   } esc_state_e;

   // clock lane start-up
   typedef enum logic [2:0] {
      SEQ_OFF,
      SEQ_LP11,
      SEQ_LP01,
      SEQ_LP00,
      SEQ_HS
   } clk_seq_e;

endpackage

`default_nettype wire

// ==== verilog/dsi_ctrl_if.sv ====
// dsi control link from the register block to the lane logic
`timescale 1ns/1ps
`default_nettype none
`include "dsi_defs.svh"

interface dsi_ctrl_if
   import dsi_reg_pkg::*;
(
   input logic clk_dsi_i
);

   // static lane settings
   logic clk_en;
   logic lp_request;
   lane_route_t [`DSI_NUM_LANES-1:0] lane_route;
   logic [`DSI_NUM_LANES-1:0] lane_invert;
   logic clock_invert;

   // escape byte hand-off
   logic [7:0] esc_byte;
   logic esc_valid;
   logic esc_ready;

   modport csr (
      input clk_dsi_i,
      output clk_en, lp_request, lane_route, lane_invert, clock_invert,
      output esc_byte, esc_valid,
      input esc_ready
   );

   modport lane (
      input clk_dsi_i,
      input clk_en, lp_request, lane_route, lane_invert, clock_invert,
      input esc_byte, esc_valid,
      output esc_ready
   );

endinterface

`default_nettype wire

// ==== verilog/dsi_csr_regs.sv ====
// dsi register block with write decode, readback and the escape byte hand-off
`timescale 1ns/1ps
`default_nettype none
`include "dsi_defs.svh"

module dsi_csr_regs
   import dsi_reg_pkg::*;
(
   input  logic clk_dsi_i,
   input  logic rst_n_dsi,
   input  logic [`DSI_ADDR_W-1:0] host_addr_i,
   input  logic [`DSI_DATA_W-1:0] host_wdata_i,
   input  logic host_wr_i,
   output logic [`DSI_DATA_W-1:0] host_rdata_o,
   dsi_ctrl_if.csr ctrl,
   output logic [`DSI_TICK_W-1:0] tick_div_o,
   output logic dsi_reset_n_o,
   output logic [2:0] dsi_gpio_o
);

   csr_word_u wr_word;
   csr_word_u rd_word;
   logic [`DSI_TICK_W-1:0] tick_div_q;
   logic clk_en_q;
   logic lp_req_q;
   lane_word_s lane_q;
   logic [7:0] esc_byte_q;
   logic esc_valid_q;
   logic esc_free;

   assign wr_word = host_wdata_i;

   // a pulse in flight counts as busy
   assign esc_free = ctrl.esc_ready & ~esc_valid_q;

   //////////////////////////////////////////////////
   // register writes
   //////////////////////////////////////////////////

   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi) begin
         tick_div_q <= '0;
         clk_en_q <= 1'b0;
         lp_req_q <= 1'b0;
         lane_q <= '0;
         esc_valid_q <= 1'b0;
         dsi_reset_n_o <= 1'b0;
         dsi_gpio_o <= '0;
      end else begin
         esc_valid_q <= 1'b0;
         if (host_wr_i) begin
            case (host_addr_i)
               `DSI_REG_TICK_DIV: tick_div_q <= wr_word.raw[`DSI_TICK_W-1:0];
               `DSI_REG_CTL: begin
                  clk_en_q <= wr_word.ctl.clk_en;
                  lp_req_q <= wr_word.ctl.lp_request;
               end
               `DSI_REG_LP_TX: begin
                  if (esc_free) begin
                     esc_valid_q <= wr_word.lp_tx.valid;
                  end
               end
               `DSI_REG_GPIO: begin
                  dsi_reset_n_o <= wr_word.gpio.reset_n;
                  dsi_gpio_o <= wr_word.gpio.gpio;
               end
               `DSI_REG_LANE_CTRL: begin
                  lane_q.route <= wr_word.lane.route;
                  lane_q.invert <= wr_word.lane.invert;
                  lane_q.clock_invert <= wr_word.lane.clock_invert;
               end
               default: ;
            endcase
         end
      end
   end

   // escape payload
   always_ff @(posedge clk_dsi_i) begin
      if (host_wr_i && host_addr_i == `DSI_REG_LP_TX && esc_free) begin
         esc_byte_q <= wr_word.lp_tx.data;
      end
   end

   //////////////////////////////////////////////////
   // readback
   //////////////////////////////////////////////////

   always_comb begin
      rd_word = '0;
      case (host_addr_i)
         `DSI_REG_TICK_DIV: rd_word.raw[`DSI_TICK_W-1:0] = tick_div_q;
         `DSI_REG_CTL: begin
            rd_word.ctl.clk_en = clk_en_q;
            rd_word.ctl.lp_request = lp_req_q;
            rd_word.ctl.esc_ready = esc_free;
         end
         `DSI_REG_GPIO: begin
            rd_word.gpio.reset_n = dsi_reset_n_o;
            rd_word.gpio.gpio = dsi_gpio_o;
         end
         `DSI_REG_LANE_CTRL: rd_word.lane = lane_q;
         default: rd_word = '0;
      endcase
   end

   // sampled only on cycles without a write
   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi) begin
         host_rdata_o <= '0;
      end else if (!host_wr_i) begin
         host_rdata_o <= rd_word.raw;
      end
   end

   assign tick_div_o = tick_div_q;
   assign ctrl.clk_en = clk_en_q;
   assign ctrl.lp_request = lp_req_q;
   assign ctrl.lane_route = lane_q.route[`DSI_NUM_LANES-1:0];
   assign ctrl.lane_invert = lane_q.invert[`DSI_NUM_LANES-1:0];
   assign ctrl.clock_invert = lane_q.clock_invert;
   assign ctrl.esc_byte = esc_byte_q;
   assign ctrl.esc_valid = esc_valid_q;

   // the transmitter must be ready whenever a byte is offered
   a_esc_handshake: assert property (@(posedge ctrl.clk_dsi_i) disable iff (!rst_n_dsi)
      $rose(ctrl.esc_valid) |-> ctrl.esc_ready)
      else $error("escape pulse raised while the transmitter is busy");

endmodule

`default_nettype wire

// ==== verilog/dsi_tick_gen.sv ====
// dsi tick generator, divides the byte clock down to the low-power bit period
`timescale 1ns/1ps
`default_nettype none
`include "dsi_defs.svh"

module dsi_tick_gen (
   input  logic clk_dsi_i,
   input  logic rst_n_dsi,
   input  logic [`DSI_TICK_W-1:0] tick_div_i,
   output logic tick_o
);

   logic [`DSI_TICK_W-1:0] count_q;

   // one tick every tick_div_i+1 cycles
   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi) begin
         count_q <= '0;
         tick_o <= 1'b0;
      end else if (count_q >= tick_div_i) begin
         // >= so a smaller divider takes effect at once
         count_q <= '0;
         tick_o <= 1'b1;
      end else begin
         count_q <= count_q + 1'b1;
         tick_o <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/dsi_lp_escape_tx.sv ====
// dsi escape transmitter, shifts a byte out as low-power line states
`timescale 1ns/1ps
`default_nettype none

module dsi_lp_escape_tx
   import dsi_lane_pkg::*;
(
   input  logic clk_dsi_i,
   input  logic rst_n_dsi,
   input  logic tick_i,
   dsi_ctrl_if.lane ctrl,
   output lp_state_e esc_state_o
);

   esc_state_e state_q;
   logic [7:0] shift_q;
   logic [3:0] bit_cnt_q;
   logic busy_q;
   logic ready_q;
   logic take;

   assign take = ctrl.esc_valid & ready_q;
   assign ctrl.esc_ready = ready_q;

   //////////////////////////////////////////////////
   // control FSM, steps only on ticks
   //////////////////////////////////////////////////

   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi) begin
         state_q <= ESC_IDLE;
         bit_cnt_q <= '0;
         busy_q <= 1'b0;
         ready_q <= 1'b0;
      end else begin
         if (take) begin
            busy_q <= 1'b1;
            ready_q <= 1'b0;
         end else if (state_q == ESC_IDLE && !busy_q) begin
            // one cycle into the closing LP-11
            ready_q <= 1'b1;
         end
         if (tick_i) begin
            case (state_q)
               ESC_IDLE: begin
                  if (busy_q) begin
                     state_q <= ESC_BIT;
                     bit_cnt_q <= '0;
                  end
               end
               ESC_BIT: state_q <= ESC_SPACE;
               ESC_SPACE: begin
                  if (bit_cnt_q == 4'd7) begin
                     state_q <= ESC_IDLE;
                     busy_q <= 1'b0;
                  end else begin
                     bit_cnt_q <= bit_cnt_q + 1'b1;
                     state_q <= ESC_BIT;
                  end
               end
               default: state_q <= ESC_IDLE;
            endcase
         end
      end
   end

   // msb first, next bit after each space
   always_ff @(posedge clk_dsi_i) begin
      if (take) begin
         shift_q <= ctrl.esc_byte;
      end else if (tick_i && state_q == ESC_SPACE) begin
         shift_q <= {shift_q[6:0], 1'b0};
      end
   end

   always_comb begin
      case (state_q)
         ESC_BIT: esc_state_o = shift_q[7] ? LP10 : LP01;
         ESC_SPACE: esc_state_o = LP00;
         default: esc_state_o = LP11;
      endcase
   end

   a_bit_cnt_range: assert property (@(posedge ctrl.clk_dsi_i) disable iff (!rst_n_dsi)
      bit_cnt_q < 4'd8)
      else $error("escape bit counter ran past the last bit");

endmodule

`default_nettype wire

// ==== verilog/dsi_lane_router.sv ====
// dsi lane router, per-lane escape routing and polarity with registered lines
`timescale 1ns/1ps
`default_nettype none
`include "dsi_defs.svh"

module dsi_lane_router
   import dsi_lane_pkg::*;
(
   input  logic clk_dsi_i,
   input  logic rst_n_dsi,
   dsi_ctrl_if.lane ctrl,
   input  lp_state_e esc_state_i,
   output logic [`DSI_NUM_LANES-1:0] dsi_lp_p_o,
   output logic [`DSI_NUM_LANES-1:0] dsi_lp_n_o,
   output logic [`DSI_NUM_LANES-1:0] dsi_lp_oe_o
);

   lp_state_e line [`DSI_NUM_LANES];

   // nonzero route parks the lane at LP-11
   always_comb begin
      for (int i = 0; i < `DSI_NUM_LANES; i++) begin
         if (!ctrl.lp_request) begin
            line[i] = LP00;
         end else if (ctrl.lane_route[i] == '0) begin
            line[i] = esc_state_i;
         end else begin
            line[i] = LP11;
         end
      end
   end

   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi) begin
         dsi_lp_p_o <= '0;
         dsi_lp_n_o <= '0;
         dsi_lp_oe_o <= '0;
      end else begin
         for (int i = 0; i < `DSI_NUM_LANES; i++) begin
            // inverted lanes swap p and n
            dsi_lp_p_o[i] <= ctrl.lane_invert[i] ? line[i][0] : line[i][1];
            dsi_lp_n_o[i] <= ctrl.lane_invert[i] ? line[i][1] : line[i][0];
         end
         dsi_lp_oe_o <= {`DSI_NUM_LANES{ctrl.lp_request}};
      end
   end

endmodule

`default_nettype wire

// ==== verilog/dsi_clock_lane.sv ====
// dsi clock lane, low-power start-up sequence then the high-speed clock byte
`timescale 1ns/1ps
`default_nettype none
`include "dsi_defs.svh"

module dsi_clock_lane
   import dsi_lane_pkg::*;
(
   input  logic clk_dsi_i,
   input  logic rst_n_dsi,
   input  logic tick_i,
   dsi_ctrl_if.lane ctrl,
   output logic dsi_clk_lp_p_o,
   output logic dsi_clk_lp_n_o,
   output logic dsi_clk_lp_oe_o,
   output logic [7:0] serdes_clk_data_o,
   output logic serdes_clk_oe_o
);

   clk_seq_e state_q;
   lp_state_e line;
   logic [7:0] pattern;

   // one step per tick, a cleared enable falls back to LP-11
   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi) begin
         state_q <= SEQ_OFF;
      end else if (tick_i) begin
         case (state_q)
            SEQ_OFF: state_q <= SEQ_LP11;
            SEQ_LP11: begin
               if (ctrl.clk_en) begin
                  state_q <= SEQ_LP01;
               end
            end
            SEQ_LP01: state_q <= ctrl.clk_en ? SEQ_LP00 : SEQ_LP11;
            SEQ_LP00: state_q <= ctrl.clk_en ? SEQ_HS : SEQ_LP11;
            SEQ_HS: begin
               if (!ctrl.clk_en) begin
                  state_q <= SEQ_LP11;
               end
            end
            default: state_q <= SEQ_OFF;
         endcase
      end
   end

   always_comb begin
      if (!ctrl.lp_request) begin
         line = LP00;
      end else begin
         case (state_q)
            SEQ_LP11: line = LP11;
            SEQ_LP01: line = LP01;
            default: line = LP00;
         endcase
      end
   end

   assign dsi_clk_lp_p_o = ctrl.clock_invert ? line[0] : line[1];
   assign dsi_clk_lp_n_o = ctrl.clock_invert ? line[1] : line[0];
   assign dsi_clk_lp_oe_o = ctrl.lp_request &&
                            (state_q inside {SEQ_LP11, SEQ_LP01, SEQ_LP00});

   // inverted polarity sends the complement
   assign pattern = ctrl.clock_invert ? ~`DSI_CLK_PATTERN : `DSI_CLK_PATTERN;
   assign serdes_clk_oe_o = (state_q == SEQ_HS);
   assign serdes_clk_data_o = serdes_clk_oe_o ? pattern : 8'h00;

   a_drivers_exclusive: assert property (@(posedge ctrl.clk_dsi_i) disable iff (!rst_n_dsi)
      !(serdes_clk_oe_o && dsi_clk_lp_oe_o))
      else $error("clock lane HS and LP drivers enabled together");

endmodule

`default_nettype wire

// ==== verilog/dsi_core_top.sv ====
// dsi core top, low-power control side in the byte clock domain
`timescale 1ns/1ps
`default_nettype none
`include "dsi_defs.svh"

module dsi_core_top
   import dsi_lane_pkg::*;
(
   input  logic clk_dsi_i,
   input  logic rst_n_dsi,
   // host register port
   input  logic [`DSI_ADDR_W-1:0] host_addr_i,
   input  logic [`DSI_DATA_W-1:0] host_wdata_i,
   input  logic host_wr_i,
   output logic [`DSI_DATA_W-1:0] host_rdata_o,
   // data lanes
   output logic [`DSI_NUM_LANES-1:0] dsi_lp_p_o,
   output logic [`DSI_NUM_LANES-1:0] dsi_lp_n_o,
   output logic [`DSI_NUM_LANES-1:0] dsi_lp_oe_o,
   // clock lane
   output logic dsi_clk_lp_p_o,
   output logic dsi_clk_lp_n_o,
   output logic dsi_clk_lp_oe_o,
   output logic [7:0] serdes_clk_data_o,
   output logic serdes_clk_oe_o,
   // display pins
   output logic dsi_reset_n_o,
   output logic [2:0] dsi_gpio_o
);

   logic [`DSI_TICK_W-1:0] tick_div;
   logic tick;
   lp_state_e esc_state;

   dsi_ctrl_if u_ctrl_if (.clk_dsi_i(clk_dsi_i));

   //////////////////////////////////////////////////
   // registers and bit timing
   //////////////////////////////////////////////////

   dsi_csr_regs u_csr_regs (
      .clk_dsi_i(clk_dsi_i),
      .rst_n_dsi(rst_n_dsi),
      .host_addr_i(host_addr_i),
      .host_wdata_i(host_wdata_i),
      .host_wr_i(host_wr_i),
      .host_rdata_o(host_rdata_o),
      .ctrl(u_ctrl_if.csr),
      .tick_div_o(tick_div),
      .dsi_reset_n_o(dsi_reset_n_o),
      .dsi_gpio_o(dsi_gpio_o)
   );

   dsi_tick_gen u_tick_gen (
      .clk_dsi_i(clk_dsi_i),
      .rst_n_dsi(rst_n_dsi),
      .tick_div_i(tick_div),
      .tick_o(tick)
   );

   //////////////////////////////////////////////////
   // lanes
   //////////////////////////////////////////////////

   dsi_lp_escape_tx u_escape_tx (
      .clk_dsi_i(clk_dsi_i),
      .rst_n_dsi(rst_n_dsi),
      .tick_i(tick),
      .ctrl(u_ctrl_if.lane),
      .esc_state_o(esc_state)
   );

   dsi_lane_router u_lane_router (
      .clk_dsi_i(clk_dsi_i),
      .rst_n_dsi(rst_n_dsi),
      .ctrl(u_ctrl_if.lane),
      .esc_state_i(esc_state),
      .dsi_lp_p_o(dsi_lp_p_o),
      .dsi_lp_n_o(dsi_lp_n_o),
      .dsi_lp_oe_o(dsi_lp_oe_o)
   );

   dsi_clock_lane u_clock_lane (
      .clk_dsi_i(clk_dsi_i),
      .rst_n_dsi(rst_n_dsi),
      .tick_i(tick),
      .ctrl(u_ctrl_if.lane),
      .dsi_clk_lp_p_o(dsi_clk_lp_p_o),
      .dsi_clk_lp_n_o(dsi_clk_lp_n_o),
      .dsi_clk_lp_oe_o(dsi_clk_lp_oe_o),
      .serdes_clk_data_o(serdes_clk_data_o),
      .serdes_clk_oe_o(serdes_clk_oe_o)
   );

endmodule

`default_nettype wire

// ==== verif/tb_dsi_core.sv ====
// testbench for the dsi core, register port, escape lanes and clock lane start-up
`timescale 1ns/1ps
`default_nettype none
`include "dsi_defs.svh"

module tb_dsi_core
   import dsi_lane_pkg::*;
();

   localparam int POLL_LIMIT = 400;

   logic clk_dsi_i;
   logic rst_n_dsi;
   logic [`DSI_ADDR_W-1:0] host_addr_i;
   logic [`DSI_DATA_W-1:0] host_wdata_i;
   logic host_wr_i;
   logic [`DSI_DATA_W-1:0] host_rdata_o;
   logic [`DSI_NUM_LANES-1:0] dsi_lp_p_o;
   logic [`DSI_NUM_LANES-1:0] dsi_lp_n_o;
   logic [`DSI_NUM_LANES-1:0] dsi_lp_oe_o;
   logic dsi_clk_lp_p_o;
   logic dsi_clk_lp_n_o;
   logic dsi_clk_lp_oe_o;
   logic [7:0] serdes_clk_data_o;
   logic serdes_clk_oe_o;
   logic dsi_reset_n_o;
   logic [2:0] dsi_gpio_o;

   integer seed;
   int errors;
   int checks;
   int tests;
   logic [31:0] reg_model [0:4];
   logic [7:0] exp_byte;
   int rx_count [3];
   int exp_count [3];
   int active_cycles [3];
   int nbits [3];
   logic [7:0] shreg [3];
   logic [1:0] prev_st [3];
   logic [1:0] clk_seq_seen [8];
   int clk_seq_len;

   dsi_core_top dut (.*);

   initial begin
      clk_dsi_i = 1'b0;
      forever #10 clk_dsi_i = ~clk_dsi_i;
   end

   //////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////

   function automatic logic [31:0] ref_readback(input int addr, input logic ready);
      case (addr)
         `DSI_REG_TICK_DIV: return {20'h0, reg_model[0][11:0]};
         `DSI_REG_CTL: return {29'h0, ready, reg_model[1][1:0]};
         `DSI_REG_GPIO: return {28'h0, reg_model[3][3:0]};
         `DSI_REG_LANE_CTRL: return {19'h0, reg_model[4][12:0]};
         default: return 32'h0;
      endcase
   endfunction

   // zero route carries escape data
   function automatic logic ref_lane_carries(input int lane);
      return reg_model[4][2*lane +: 2] == 2'b00;
   endfunction

   function automatic logic [7:0] ref_clk_byte(input logic inv);
      return inv ? 8'h55 : 8'haa;
   endfunction

   function automatic lp_state_e ref_clk_seq(input int step);
      case (step)
         0: return LP11;
         1: return LP01;
         default: return LP00;
      endcase
   endfunction

   // logical {p, n} with the lane swap undone
   function automatic logic [1:0] decode_line(input logic p, input logic n, input logic inv);
      return inv ? {n, p} : {p, n};
   endfunction

   //////////////////////////////////////////////////
   // host and check tasks
   //////////////////////////////////////////////////

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string msg);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t: %s, got %h expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic timeout_fail(input string what);
      $display("timeout while waiting for %s at %0t", what, $time);
      $display("ERRORS FOUND");
      $finish;
   endtask

   task automatic finish_test(input string name, input int errors_before);
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == errors_before) ? "ok" : "failed");
   endtask

   task automatic write_reg(input logic [5:0] addr, input logic [31:0] data);
      @(posedge clk_dsi_i);
      host_addr_i <= addr;
      host_wdata_i <= data;
      host_wr_i <= 1'b1;
      @(posedge clk_dsi_i);
      host_wr_i <= 1'b0;
      if (addr <= `DSI_REG_LANE_CTRL) begin
         reg_model[addr] = data;
      end
   endtask

   task automatic read_reg(input logic [5:0] addr, output logic [31:0] data);
      @(posedge clk_dsi_i);
      host_addr_i <= addr;
      host_wr_i <= 1'b0;
      @(posedge clk_dsi_i);
      @(negedge clk_dsi_i);
      data = host_rdata_o;
   endtask

   // poll CTL bit 2
   task automatic wait_ready();
      logic [31:0] r;
      int n;
      n = 0;
      read_reg(`DSI_REG_CTL, r);
      while (!r[2] && n < POLL_LIMIT) begin
         read_reg(`DSI_REG_CTL, r);
         n++;
      end
      if (!r[2]) begin
         timeout_fail("the escape ready bit");
      end
   endtask

   task automatic send_byte(input logic [7:0] b);
      wait_ready();
      exp_byte = b;
      for (int l = 0; l < 3; l++) begin
         if (ref_lane_carries(l)) begin
            exp_count[l]++;
         end
      end
      write_reg(`DSI_REG_LP_TX, {23'h0, 1'b1, b});
   endtask

   // enable, watch LP states up to HS, then disable
   task automatic run_clock_start(input string label);
      logic [1:0] st;
      int n;
      write_reg(`DSI_REG_CTL, 32'h3);
      clk_seq_len = 0;
      n = 0;
      while (!serdes_clk_oe_o && n < POLL_LIMIT) begin
         @(negedge clk_dsi_i);
         n++;
         if (dsi_clk_lp_oe_o) begin
            st = decode_line(dsi_clk_lp_p_o, dsi_clk_lp_n_o, reg_model[4][12]);
            if ((clk_seq_len == 0 || st != clk_seq_seen[clk_seq_len-1]) &&
                clk_seq_len < 8) begin
               clk_seq_seen[clk_seq_len] = st;
               clk_seq_len++;
            end
         end
      end
      if (!serdes_clk_oe_o) begin
         timeout_fail("the clock lane HS step");
      end
      check_value(clk_seq_len, 3, {label, " LP step count"});
      for (int i = 0; i < 3; i++) begin
         check_value(clk_seq_seen[i], ref_clk_seq(i), $sformatf("%s LP step %0d", label, i));
      end
      check_value(serdes_clk_data_o, ref_clk_byte(reg_model[4][12]), {label, " HS byte"});
      check_value(dsi_clk_lp_oe_o, 1'b0, {label, " LP enable in HS"});
      write_reg(`DSI_REG_CTL, 32'h2);
      n = 0;
      @(negedge clk_dsi_i);
      while (!dsi_clk_lp_oe_o && n < POLL_LIMIT) begin
         @(negedge clk_dsi_i);
         n++;
      end
      if (!dsi_clk_lp_oe_o) begin
         timeout_fail("the clock lane return to LP");
      end
      st = decode_line(dsi_clk_lp_p_o, dsi_clk_lp_n_o, reg_model[4][12]);
      check_value(st, LP11, {label, " state after disable"});
      check_value({serdes_clk_oe_o, serdes_clk_data_o}, 9'h0, {label, " serdes after disable"});
   endtask

   //////////////////////////////////////////////////
   // lane monitor, decodes and compares each byte
   //////////////////////////////////////////////////

   always @(negedge clk_dsi_i) begin : lane_monitor
      logic [1:0] st;
      if (rst_n_dsi) begin
         for (int l = 0; l < 3; l++) begin
            if (dsi_lp_oe_o[l]) begin
               st = decode_line(dsi_lp_p_o[l], dsi_lp_n_o[l], reg_model[4][8+l]);
               if (st != LP11) begin
                  active_cycles[l]++;
               end
               if (st != prev_st[l]) begin
                  if (st == LP10 || st == LP01) begin
                     shreg[l] = {shreg[l][6:0], st == LP10};
                     nbits[l]++;
                  end else if (st == LP11 && nbits[l] > 0) begin
                     check_value(nbits[l], 8, $sformatf("lane %0d bit count", l));
                     check_value(shreg[l], exp_byte, $sformatf("lane %0d byte", l));
                     rx_count[l]++;
                     nbits[l] = 0;
                  end
               end
               prev_st[l] = st;
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial begin : main
      logic [31:0] r;
      logic [7:0] b;
      int e0;
      int park_active;
      int park_rx;
      seed = 32'hf8444d05;
      errors = 0;
      checks = 0;
      tests = 0;
      exp_byte = 8'h00;
      for (int i = 0; i < 5; i++) begin
         reg_model[i] = 32'h0;
      end
      for (int l = 0; l < 3; l++) begin
         rx_count[l] = 0;
         exp_count[l] = 0;
         active_cycles[l] = 0;
         nbits[l] = 0;
         shreg[l] = 8'h00;
         prev_st[l] = LP00;
      end
      rst_n_dsi = 1'b0;
      host_addr_i = '0;
      host_wdata_i = '0;
      host_wr_i = 1'b0;
      repeat (10) @(posedge clk_dsi_i);
      rst_n_dsi <= 1'b1;
      @(negedge clk_dsi_i);

      e0 = errors;
      check_value(dsi_lp_oe_o, 0, "data lane enables after reset");
      check_value({dsi_clk_lp_oe_o, serdes_clk_oe_o}, 0, "clock lane enables after reset");
      check_value({dsi_reset_n_o, dsi_gpio_o}, 0, "display pins after reset");
      check_value({dsi_lp_p_o, dsi_lp_n_o, dsi_clk_lp_p_o, dsi_clk_lp_n_o}, 0,
                  "LP lines after reset");
      for (int a = 0; a < 6; a++) begin
         read_reg(a, r);
         check_value(r, ref_readback(a, 1'b1), $sformatf("reset readback at %0d", a));
      end
      finish_test("reset state", e0);

      e0 = errors;
      write_reg(`DSI_REG_TICK_DIV, 32'hffff_f5a3);
      write_reg(`DSI_REG_GPIO, 32'hffff_fffb);
      write_reg(`DSI_REG_LANE_CTRL, 32'hffff_1e6d);
      for (int a = 0; a < 5; a++) begin
         read_reg(a, r);
         check_value(r, ref_readback(a, 1'b1), $sformatf("readback at %0d", a));
      end
      check_value(dsi_reset_n_o, reg_model[3][0], "display reset pin");
      check_value(dsi_gpio_o, reg_model[3][3:1], "display gpio pins");
      finish_test("register access", e0);

      e0 = errors;
      write_reg(`DSI_REG_TICK_DIV, 32'h3);
      write_reg(`DSI_REG_LANE_CTRL, 32'h0);
      write_reg(`DSI_REG_CTL, 32'h2);
      for (int i = 0; i < 8; i++) begin
         b = $random(seed);
         send_byte(b);
      end
      wait_ready();
      for (int l = 0; l < 3; l++) begin
         check_value(rx_count[l], exp_count[l], $sformatf("lane %0d byte count", l));
      end
      finish_test("escape transfer", e0);

      // lane 1 parked, lane 2 inverted
      e0 = errors;
      write_reg(`DSI_REG_LANE_CTRL, 32'h0000_0404);
      park_active = active_cycles[1];
      park_rx = rx_count[1];
      for (int i = 0; i < 4; i++) begin
         b = $random(seed);
         send_byte(b);
      end
      wait_ready();
      for (int l = 0; l < 3; l++) begin
         check_value(rx_count[l], exp_count[l], $sformatf("lane %0d routed byte count", l));
      end
      check_value(active_cycles[1], park_active, "parked lane left LP-11");
      check_value(rx_count[1], park_rx, "parked lane bytes");
      write_reg(`DSI_REG_LANE_CTRL, 32'h0);
      finish_test("route and polarity", e0);

      e0 = errors;
      run_clock_start("clock normal");
      write_reg(`DSI_REG_LANE_CTRL, 32'h0000_1000);
      run_clock_start("clock inverted");
      write_reg(`DSI_REG_LANE_CTRL, 32'h0);
      finish_test("clock lane", e0);

      // second write lands while the first byte is in flight
      e0 = errors;
      b = $random(seed);
      send_byte(b);
      b = $random(seed);
      write_reg(`DSI_REG_LP_TX, {23'h0, 1'b1, b});
      wait_ready();
      for (int l = 0; l < 3; l++) begin
         check_value(rx_count[l], exp_count[l], $sformatf("lane %0d busy write count", l));
      end
      finish_test("busy write", e0);

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
verilog/dsi_reg_pkg.sv
verilog/dsi_lane_pkg.sv
verilog/dsi_ctrl_if.sv
verilog/dsi_csr_regs.sv
verilog/dsi_tick_gen.sv
verilog/dsi_lp_escape_tx.sv
verilog/dsi_lane_router.sv
verilog/dsi_clock_lane.sv
verilog/dsi_core_top.sv
verif/tb_dsi_core.sv
